//--- include/mboxTbUtil.svh
// Testbench constants, expected-word queues and check tasks, included inside the mbox testbench
`ifndef MBOX_TB_UTIL_SVH
`define MBOX_TB_UTIL_SVH

////////////////////
// Run setup
////////////////////

localparam int ClkPeriod = 4;
localparam int NumWriteBacks = 200;
localparam int CyclesPerWb = 60;
localparam int RandSeed = 86389;
localparam int TbCredits = 2;

// Expected words in send order
mboxPkg::wordIdx expWord[$];
mboxPkg::mbWord expData[$];
logic expPar[$];

// Word and parity bit together hold an odd count of ones
function automatic logic oddParity(input mboxPkg::mbWord data);
  int ones;
  ones = 0;
  for (int i = 0; i < mboxPkg::WordBits; i++) begin
    if (data[i]) begin
      ones++;
    end
  end
  return (ones % 2) == 0;
endfunction

task automatic pushExpected(input mboxPkg::wordIdx idx, input mboxPkg::mbWord data);
  expWord.push_back(idx);
  expData.push_back(data);
  expPar.push_back(oddParity(data));
endtask

////////////////////
// Checks
////////////////////

// First failure ends the run
task automatic stopRun(input string reason);
  $display("STATUS: FAIL");
  $fatal(1, "%s", reason);
endtask

task automatic reportMismatch(input string testName, input logic [63:0] expected,
                              input logic [63:0] actual);
  $display("error %s: expected %0h, actual %0h", testName, expected, actual);
  stopRun("value mismatch");
endtask

task automatic reportFailure(input string what);
  $display("failure: %s", what);
  stopRun(what);
endtask

task automatic checkEqual(input string testName, input logic [63:0] expected,
                          input logic [63:0] actual);
  assert (actual === expected) else reportMismatch(testName, expected, actual);
endtask

task automatic checkTrue(input logic cond, input string what);
  assert (cond) else reportFailure(what);
endtask

`endif

//--- bench/mboxTb.sv
// Random write-back testbench for mbox with cache and memory responders and a send-order model
`default_nettype none

module mboxTb
  import mboxPkg::*;
();

  `include "mboxTbUtil.svh"

  logic clk;
  logic rstN;
  logic wbStart;
  wordMask wbMask;
  logic wbReady;
  logic cshRdEn;
  wordIdx cshRdWord;
  mbWord cshRdData;
  logic memValid;
  wordIdx memWord;
  mbWord memData;
  logic memPar;
  logic memCredit;

  // Cache reads still owed for accepted write-backs
  wordIdx fetchExp[$];
  int acceptCount;

  mbox #(
    .MemCredits (TbCredits)
  ) i_mbox (
    .clk       (clk),
    .rstN      (rstN),
    .wbStart   (wbStart),
    .wbMask    (wbMask),
    .wbReady   (wbReady),
    .cshRdEn   (cshRdEn),
    .cshRdWord (cshRdWord),
    .cshRdData (cshRdData),
    .memValid  (memValid),
    .memWord   (memWord),
    .memData   (memData),
    .memPar    (memPar),
    .memCredit (memCredit)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic driveWriteBacks();
    wordMask mask;
    int gap;
    for (int n = 0; n < NumWriteBacks; n++) begin
      // Mostly wait for ready, sometimes start into a busy buffer
      if ($urandom % 4 != 0) begin
        while (!wbReady) begin
          @(negedge clk);
        end
      end
      mask = ($urandom % 8 == 0) ? '0 : wordMask'($urandom);
      wbStart = 1'b1;
      wbMask = mask;
      if (wbReady && mask != '0) begin
        for (int w = 0; w < LineWords; w++) begin
          if (mask[w]) begin
            fetchExp.push_back(wordIdx'(w));
          end
        end
        acceptCount++;
      end
      @(negedge clk);
      wbStart = 1'b0;
      wbMask = wordMask'($urandom);
      gap = $urandom % 4;
      repeat (gap) @(negedge clk);
    end
  endtask

  // Reads are checked against the mask order and answered one cycle later
  task automatic answerCacheReads();
    logic readPending;
    wordIdx readIdx;
    mbWord data;
    readPending = 1'b0;
    readIdx = '0;
    forever begin
      @(negedge clk);
      data = mbWord'({$urandom, $urandom});
      cshRdData = data;
      if (readPending) begin
        pushExpected(readIdx, data);
      end
      readPending = 1'b0;
      if (cshRdEn) begin
        checkTrue(fetchExp.size() > 0, "cache read for a word outside the mask");
        checkEqual("cacheReadOrder", fetchExp[0], cshRdWord);
        readIdx = fetchExp.pop_front();
        readPending = 1'b1;
      end
    end
  endtask

  // Credits come back after a short delay, now and then after a long stall
  task automatic answerMemory();
    int cycle;
    int delay;
    int slot;
    int outstanding;
    int due[$];
    cycle = 0;
    outstanding = 0;
    forever begin
      @(negedge clk);
      cycle++;
      memCredit = 1'b0;
      if (memValid) begin
        checkTrue(outstanding < TbCredits, "memValid high with no credit left");
        outstanding++;
        delay = ($urandom % 8 == 0) ? 10 + int'($urandom % 20) : int'($urandom % 6);
        due.push_back(cycle + 1 + delay);
      end
      slot = -1;
      foreach (due[i]) begin
        if (slot < 0 && due[i] <= cycle) begin
          slot = i;
        end
      end
      if (slot >= 0) begin
        due.delete(slot);
        memCredit = 1'b1;
        outstanding--;
      end
    end
  endtask

  ////////////////////
  // Monitors
  ////////////////////

  always @(negedge clk) begin
    checkTrue(i_mbox.i_assertions.failCount == 0, "a concurrent assertion on mbox failed");
    if (rstN) begin
      if (memValid) begin
        checkTrue(expWord.size() > 0, "memory send with no buffered word expected");
        checkEqual("memWord", expWord.pop_front(), memWord);
        checkEqual("memData", expData.pop_front(), memData);
        checkEqual("memPar", expPar.pop_front(), memPar);
      end
      if (wbReady) begin
        checkTrue(expWord.size() == 0, "wbReady high before the line was sent");
      end
    end
  end

  initial begin
    #(NumWriteBacks * CyclesPerWb * ClkPeriod);
    $display("watchdog expired before the write-backs drained");
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    void'($urandom(RandSeed));
    clk = 1'b0;
    rstN = 1'b0;
    wbStart = 1'b0;
    wbMask = '0;
    cshRdData = '0;
    memCredit = 1'b0;
    acceptCount = 0;
    repeat (3) @(negedge clk);
    rstN = 1'b1;
    checkEqual("resetReady", 1'b1, wbReady);
    checkEqual("resetCshRdEn", 1'b0, cshRdEn);
    checkEqual("resetMemValid", 1'b0, memValid);
    fork
      driveWriteBacks();
      answerCacheReads();
      answerMemory();
    join_any
    while (!wbReady) begin
      @(negedge clk);
    end
    checkTrue(acceptCount > 0, "no write-back was accepted");
    checkEqual("finalQueue", 0, expWord.size());
    checkEqual("finalFetch", 0, fetchExp.size());
    checkEqual("assertionFailures", 0, i_mbox.i_assertions.failCount);
    $display("%0d write-backs accepted", acceptCount);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/mbox_assertions.sv
// Concurrent port checks for the mbox top level, bound into every mbox instance
`default_nettype none

module mboxAssertions #(
  parameter int MaxOutstanding = 2
) (
  input wire logic clk,
  input wire logic rstN,
  input wire logic wbReady,
  input wire logic cshRdEn,
  input wire logic memValid,
  input wire logic memCredit
);

  // Words sent to memory and not yet paid back
  int outstanding;

  // Failed assertions so far, watched by the testbench
  int failCount;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(memValid) - int'(memCredit);
    end
  end

  noSendInReset: assert property (@(posedge clk) !rstN |-> !memValid)
    else begin
      $error("memValid high while reset is active");
      failCount++;
    end

  readyExcludesRead: assert property (@(posedge clk) disable iff (!rstN) !(wbReady && cshRdEn))
    else begin
      $error("wbReady and cshRdEn high together");
      failCount++;
    end

  creditLimit: assert property (@(posedge clk) disable iff (!rstN)
    outstanding <= MaxOutstanding)
    else begin
      $error("more words in flight than memory credits");
      failCount++;
    end

endmodule

bind mbox mboxAssertions #(
  .MaxOutstanding (MemCredits)
) i_assertions (
  .clk       (clk),
  .rstN      (rstN),
  .wbReady   (wbReady),
  .cshRdEn   (cshRdEn),
  .memValid  (memValid),
  .memCredit (memCredit)
);

`default_nettype wire

//--- mbox.f
+incdir+include
verilog/mboxPkg.sv
verilog/memBuffer.sv
verilog/memRequestArbiter.sv
verilog/cacheToMbSequencer.sv
verilog/mbox.sv
bench/mbox_assertions.sv
bench/mboxTb.sv

//--- verilog/cacheToMbSequencer.sv
// Write-back sequencer that fetches masked line words from the cache into the buffer
`default_nettype none

module cacheToMbSequencer
  import mboxPkg::*;
(
  input  wire logic    clk,
  input  wire logic    rstN,

  // Write-back request from the cache side
  input  wire logic    wbStart,
  input  wire wordMask wbMask,

  // Arbiter still holds unsent words
  input  wire logic    linePending,

  output logic         wbReady,

  // Cache read, data comes back one cycle later
  output logic         cshRdEn,
  output wordIdx       cshRdWord,

  // Buffer write, one cycle behind the read
  output logic         wrEn,
  output wordIdx       wrIdx
);

  seqState state;
  seqState stateNext;

  // Words of the line not yet read from the cache
  wordMask fetchMask;
  wordMask fetchNext;
  wordMask fetchBit;

  logic accept;

  ////////////////////
  // Handshake
  ////////////////////

  assign wbReady = (state == seqIdle);

  // Empty masks are dropped here
  assign accept = wbReady && wbStart && (wbMask != '0);

  ////////////////////
  // Cache read
  ////////////////////

  assign cshRdEn = (state == seqFetch);
  assign cshRdWord = lowestWord(fetchMask);
  assign fetchBit = wordMask'(1) << cshRdWord;

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    stateNext = state;
    fetchNext = fetchMask;
    case (state)
      seqIdle: begin
        if (accept) begin
          fetchNext = wbMask;
          stateNext = seqFetch;
        end
      end
      seqFetch: begin
        // One word per cycle, lowest first
        fetchNext = fetchMask & ~fetchBit;
        if (fetchNext == '0) begin
          stateNext = seqDrain;
        end
      end
      seqDrain: begin
        // Last write may still sit in the delay stage
        if (!linePending && !wrEn) begin
          stateNext = seqIdle;
        end
      end
      default: begin
        stateNext = seqIdle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= seqIdle;
      fetchMask <= '0;
      wrEn <= 1'b0;
    end else begin
      state <= stateNext;
      fetchMask <= fetchNext;
      wrEn <= cshRdEn;
    end
  end

  // Index follows the read into the write cycle
  always_ff @(posedge clk) begin
    wrIdx <= cshRdWord;
  end

endmodule

`default_nettype wire

//--- verilog/mbox.sv
// Top level of the write-back memory buffer, joining the sequencer, buffer and memory arbiter
`default_nettype none

module mbox
  import mboxPkg::*;
#(
  parameter int MemCredits = 2
) (
  input  wire logic    clk,
  input  wire logic    rstN,

  ////////////////////
  // Cache side
  ////////////////////

  input  wire logic    wbStart,
  input  wire wordMask wbMask,
  output logic         wbReady,

  output logic         cshRdEn,
  output wordIdx       cshRdWord,
  input  wire mbWord   cshRdData,

  ////////////////////
  // Memory side
  ////////////////////

  output logic         memValid,
  output wordIdx       memWord,
  output mbWord        memData,
  output logic         memPar,
  input  wire logic    memCredit
);

  // Buffer write from the sequencer delay stage
  logic wrEn;
  wordIdx wrIdx;

  // Arbiter view of the buffer
  wordIdx rdIdx;
  logic linePending;

  cacheToMbSequencer i_sequencer (
    .clk         (clk),
    .rstN        (rstN),
    .wbStart     (wbStart),
    .wbMask      (wbMask),
    .linePending (linePending),
    .wbReady     (wbReady),
    .cshRdEn     (cshRdEn),
    .cshRdWord   (cshRdWord),
    .wrEn        (wrEn),
    .wrIdx       (wrIdx)
  );

  memBuffer i_buffer (
    .clk    (clk),
    .rstN   (rstN),
    .wrEn   (wrEn),
    .wrIdx  (wrIdx),
    .wrData (cshRdData),
    .rdIdx  (rdIdx),
    .rdData (memData),
    .rdPar  (memPar)
  );

  memRequestArbiter #(
    .MemCredits (MemCredits)
  ) i_arbiter (
    .clk         (clk),
    .rstN        (rstN),
    .wrEn        (wrEn),
    .wrIdx       (wrIdx),
    .memCredit   (memCredit),
    .rdIdx       (rdIdx),
    .memValid    (memValid),
    .memWord     (memWord),
    .linePending (linePending)
  );

endmodule

`default_nettype wire

//--- verilog/mboxPkg.sv
// Shared widths, word types and sequencer states for the mbox design, imported by each RTL module
`default_nettype none

package mboxPkg;

  ////////////////////
  // Line geometry
  ////////////////////

  // One memory word, as stored in the buffer
  localparam int WordBits = 36;

  // Words per cache line and entries in the buffer
  localparam int LineWords = 4;

  ////////////////////
  // Types
  ////////////////////

  typedef logic [WordBits-1:0] mbWord;

  // Word position within the line
  typedef logic [$clog2(LineWords)-1:0] wordIdx;

  // Bit n stands for word n
  typedef logic [LineWords-1:0] wordMask;

  typedef enum logic [1:0] {
    seqIdle,
    seqFetch,
    seqDrain
  } seqState;

  // Lowest set bit of a word mask, zero when the mask is empty
  function automatic wordIdx lowestWord(input wordMask mask);
    wordIdx idx;
    idx = '0;
    // Walk down so the lowest set bit is the last one to land
    for (int i = LineWords - 1; i >= 0; i--) begin
      if (mask[i]) begin
        idx = wordIdx'(i);
      end
    end
    return idx;
  endfunction

endpackage

`default_nettype wire

//--- verilog/memBuffer.sv
// Four-entry memory buffer holding write-back words with odd parity, read by word index
`default_nettype none

module memBuffer
  import mboxPkg::*;
(
  input  wire logic   clk,
  input  wire logic   rstN,

  // Write port, fed from the cache read data
  input  wire logic   wrEn,
  input  wire wordIdx wrIdx,
  input  wire mbWord  wrData,

  // Read port toward memory
  input  wire wordIdx rdIdx,
  output mbWord       rdData,
  output logic        rdPar
);

  ////////////////////
  // Storage
  ////////////////////

  mbWord words [LineWords];
  wordMask parBits;

  // Odd parity of the incoming word
  logic wrPar;

  assign wrPar = ~^wrData;

  // Cleared entries hold a zero word with good parity
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < LineWords; i++) begin
        words[i] <= '0;
      end
      parBits <= '1;
    end else if (wrEn) begin
      words[wrIdx] <= wrData;
      parBits[wrIdx] <= wrPar;
    end
  end

  ////////////////////
  // Read select
  ////////////////////

  // Plain mux, no read latency
  always_comb begin
    rdData = words[rdIdx];
    rdPar = parBits[rdIdx];
  end

endmodule

`default_nettype wire

//--- verilog/memRequestArbiter.sv
// Write request tracking, lowest-word selection and memory credit count for the mbox buffer
`default_nettype none

module memRequestArbiter
  import mboxPkg::*;
#(
  parameter int MemCredits = 2
) (
  input  wire logic   clk,
  input  wire logic   rstN,

  // Buffer writes from the sequencer
  input  wire logic   wrEn,
  input  wire wordIdx wrIdx,

  // One pulse per returned credit
  input  wire logic   memCredit,

  output wordIdx      rdIdx,
  output logic        memValid,
  output wordIdx      memWord,
  output logic        linePending
);

  localparam int CreditBits = $clog2(MemCredits + 1);

  typedef logic [CreditBits-1:0] creditCnt;

  localparam creditCnt CreditsFull = creditCnt'(MemCredits);

  wordMask reqBits;
  wordMask reqSet;
  wordMask reqClr;
  wordIdx selIdx;
  creditCnt credits;
  logic sendNow;

  ////////////////////
  // Selection
  ////////////////////

  assign linePending = |reqBits;

  // Lowest pending word goes first
  assign selIdx = lowestWord(reqBits);
  assign rdIdx = selIdx;
  assign memWord = selIdx;

  // No ready from memory, a held credit is the permission to send
  assign memValid = linePending && (credits != '0);
  assign sendNow = memValid;

  ////////////////////
  // Request bits
  ////////////////////

  always_comb begin
    reqSet = '0;
    reqClr = '0;
    if (wrEn) begin
      reqSet[wrIdx] = 1'b1;
    end
    if (sendNow) begin
      reqClr[selIdx] = 1'b1;
    end
  end

  // A word being written is never the one being sent
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      reqBits <= '0;
    end else begin
      reqBits <= (reqBits & ~reqClr) | reqSet;
    end
  end

  ////////////////////
  // Credits
  ////////////////////

  // Send and return on the same edge cancel out
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      credits <= CreditsFull;
    end else begin
      case ({sendNow, memCredit})
        2'b10: begin
          credits <= credits - creditCnt'(1);
        end
        2'b01: begin
          // Saturate at the starting count
          if (credits != CreditsFull) begin
            credits <= credits + creditCnt'(1);
          end
        end
        default: begin
          credits <= credits;
        end
      endcase
    end
  end

endmodule

`default_nettype wire
